// File: list.f
+incdir+dv
common/membus_pkg.sv
logic/stall_lfsr.sv
bus_fsm/bus_fsm.sv
logic/word_ram.sv
logic/serial_out.sv
logic/membus_top.sv
dv/membus_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := membus_tb
FILELIST := list.f
OBJ_DIR  := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# exit status of the binary is the test result
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/membus_ref.svh
`ifndef MEMBUS_REF_SVH
`define MEMBUS_REF_SVH

// byte mirror of the ram, indexed by byte address
byte_t mirror_q [RAM_WORDS*8];

function automatic bit in_ram(addr_t addr);
  return (addr < addr_t'(RAM_WORDS * 8)) && (addr != SERIAL_ADDR);
endfunction

function automatic addr_t word_base(addr_t addr);
  return {addr[ADDR_W-1:3], 3'b000};
endfunction

function automatic data_t expect_rdata(addr_t addr);
  data_t d;
  d = '0;
  if (in_ram(addr)) begin
    for (int b = 0; b < 8; b++) begin
      d[8*b +: 8] = mirror_q[word_base(addr) + b];
    end
  end
  return d;
endfunction

function automatic resp_t expect_rresp(addr_t addr);
  return in_ram(addr) ? RESP_OKAY : RESP_SLVERR;
endfunction

// the serial port also answers okay on writes
function automatic resp_t expect_bresp(addr_t addr);
  return (in_ram(addr) || addr == SERIAL_ADDR) ? RESP_OKAY : RESP_SLVERR;
endfunction

function automatic void mirror_write(addr_t addr, data_t data, strb_t strb);
  if (in_ram(addr)) begin
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) begin
        mirror_q[word_base(addr) + b] = data[8*b +: 8];
      end
    end
  end
endfunction

task automatic fail_run();
  $display("Verification failed");
  $fatal(1, "stopping at first error");
endtask

task automatic report_error(string why);
  $display("ERROR: %s", why);
  fail_run();
endtask

task automatic check_data(string name, data_t exp, data_t act);
  if (act !== exp) begin
    $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
    fail_run();
  end
endtask

task automatic check_resp(string name, resp_t exp, resp_t act);
  if (act !== exp) begin
    $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
    fail_run();
  end
endtask

task automatic check_byte(string name, byte_t exp, byte_t act);
  if (act !== exp) begin
    $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
    fail_run();
  end
endtask

`endif

// File: dv/membus_tb.sv
`timescale 1ns/10ps
`default_nettype none

module membus_tb import membus_pkg::*; ();

  localparam int unsigned RAM_WORDS    = 256;
  localparam addr_t       SERIAL_ADDR  = 32'h1000_03f8;
  localparam int unsigned RESET_CYCLES = 16;
  localparam int unsigned N_FULL       = 16;
  localparam int unsigned N_PART       = 12;
  localparam int unsigned N_SER        = 6;
  localparam int unsigned N_ERR        = 6;
  localparam int unsigned N_HOLD       = 10;
  localparam int unsigned N_MIX        = 40;
  // every sequence step below is one transaction
  localparam int unsigned N_TXN = 2 * N_FULL + 2 * N_PART + N_SER + 5 + 3 * N_ERR + 1
                                  + 2 * N_HOLD + N_MIX;
  localparam int unsigned TIMEOUT_CYCLES = 40 * N_TXN + RESET_CYCLES;

  logic  clk;
  logic  arst_n_i;
  addr_t araddr_i;
  logic  arvalid_i;
  logic  arready_o;
  data_t rdata_o;
  resp_t rresp_o;
  logic  rvalid_o;
  logic  rready_i;
  addr_t awaddr_i;
  logic  awvalid_i;
  logic  awready_o;
  data_t wdata_i;
  strb_t wstrb_i;
  logic  wvalid_i;
  logic  wready_o;
  resp_t bresp_o;
  logic  bvalid_o;
  logic  bready_i;
  byte_t tx_byte_o;
  logic  tx_valid_o;

  string       test_name = "reset";
  int unsigned hold_max = 0;
  data_t       rd_data_q [$];
  resp_t       rd_resp_q [$];
  resp_t       b_resp_q [$];
  byte_t       tx_q [$];
  bit          written_flag [RAM_WORDS];
  int unsigned written_q [$];
  bit          r_hold = 1'b0;
  data_t       r_hold_data;
  resp_t       r_hold_resp;
  bit          b_hold = 1'b0;
  resp_t       b_hold_resp;

  `include "membus_ref.svh"

  membus_top #(
    .RAM_WORDS   (RAM_WORDS),
    .SERIAL_ADDR (SERIAL_ADDR),
    .STALL_EN    (1'b1),
    .LFSR_SEED   (20'd101)
  ) dut_i (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .araddr_i   (araddr_i),
    .arvalid_i  (arvalid_i),
    .arready_o  (arready_o),
    .rdata_o    (rdata_o),
    .rresp_o    (rresp_o),
    .rvalid_o   (rvalid_o),
    .rready_i   (rready_i),
    .awaddr_i   (awaddr_i),
    .awvalid_i  (awvalid_i),
    .awready_o  (awready_o),
    .wdata_i    (wdata_i),
    .wstrb_i    (wstrb_i),
    .wvalid_i   (wvalid_i),
    .wready_o   (wready_o),
    .bresp_o    (bresp_o),
    .bvalid_o   (bvalid_o),
    .bready_i   (bready_i),
    .tx_byte_o  (tx_byte_o),
    .tx_valid_o (tx_valid_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic addr_t rand_ram_addr();
    int unsigned idx;
    idx = $urandom_range(RAM_WORDS - 1, 0);
    return addr_t'(idx * 8 + $urandom_range(7, 0));
  endfunction

  function automatic void mark_written(addr_t addr);
    int unsigned idx;
    idx = addr >> 3;
    if (!written_flag[idx]) begin
      written_flag[idx] = 1'b1;
      written_q.push_back(idx);
    end
  endfunction

  function automatic addr_t pick_written();
    int unsigned idx;
    idx = written_q[$urandom_range(written_q.size() - 1, 0)];
    return addr_t'(idx * 8 + $urandom_range(7, 0));
  endfunction

  // same low index at a random multiple of the ram size above it
  function automatic addr_t alias_addr(addr_t addr);
    return word_base(addr) + addr_t'(RAM_WORDS * 8 * (1 + $urandom_range(1000, 0)));
  endfunction

  // ends right after a rising edge like the other bus tasks
  task automatic accept_response(bit is_read);
    int unsigned delay;
    delay = $urandom_range(hold_max, 0);
    do @(negedge clk); while (!(is_read ? rvalid_o : bvalid_o));
    repeat (delay) @(negedge clk);
    @(posedge clk);
    if (is_read) begin
      rready_i <= 1'b1;
    end else begin
      bready_i <= 1'b1;
    end
    @(posedge clk);
    rready_i <= 1'b0;
    bready_i <= 1'b0;
  endtask

  task automatic read_txn(addr_t addr);
    rd_data_q.push_back(expect_rdata(addr));
    rd_resp_q.push_back(expect_rresp(addr));
    araddr_i  <= addr;
    arvalid_i <= 1'b1;
    do @(negedge clk); while (!arready_o);
    @(posedge clk);
    arvalid_i <= 1'b0;
    accept_response(1'b1);
  endtask

  task automatic write_txn(addr_t addr, data_t data, strb_t strb);
    b_resp_q.push_back(expect_bresp(addr));
    if (addr == SERIAL_ADDR) begin
      tx_q.push_back(data[7:0]);
    end
    mirror_write(addr, data, strb);
    awaddr_i  <= addr;
    awvalid_i <= 1'b1;
    wdata_i   <= data;
    wstrb_i   <= strb;
    wvalid_i  <= 1'b1;
    do @(negedge clk); while (!awready_o);
    @(posedge clk);
    awvalid_i <= 1'b0;
    do @(negedge clk); while (!wready_o);
    @(posedge clk);
    wvalid_i <= 1'b0;
    accept_response(1'b0);
  endtask

  task automatic run_full_words();
    addr_t addrs [$];
    addr_t a;
    test_name = "full_words";
    for (int i = 0; i < N_FULL; i++) begin
      a = rand_ram_addr();
      write_txn(a, {$urandom, $urandom}, '1);
      mark_written(a);
      addrs.push_back(a);
    end
    foreach (addrs[i]) begin
      read_txn(addrs[i]);
    end
  endtask

  task automatic run_partial_strobes();
    addr_t a;
    test_name = "partial_strobes";
    for (int i = 0; i < N_PART; i++) begin
      a = pick_written();
      write_txn(a, {$urandom, $urandom}, strb_t'($urandom_range(254, 1)));
      read_txn(a);
    end
  endtask

  task automatic run_serial_writes();
    addr_t low_addr;
    test_name = "serial_writes";
    // ram word sharing its index bits with the serial port
    low_addr = addr_t'(((SERIAL_ADDR >> 3) % RAM_WORDS) * 8);
    write_txn(low_addr, {$urandom, $urandom}, '1);
    mark_written(low_addr);
    for (int i = 0; i < N_SER; i++) begin
      write_txn(SERIAL_ADDR, {$urandom, $urandom}, '1);
    end
    // ram must not see the serial data
    read_txn(low_addr);
    repeat (3) read_txn(pick_written());
  endtask

  task automatic run_error_range();
    addr_t base;
    addr_t far;
    test_name = "error_range";
    for (int i = 0; i < N_ERR; i++) begin
      base = pick_written();
      far  = alias_addr(base);
      write_txn(far, {$urandom, $urandom}, '1);
      read_txn(far);
      read_txn(base);
    end
    read_txn(SERIAL_ADDR);
  endtask

  task automatic run_backpressure();
    addr_t a;
    test_name = "backpressure";
    hold_max  = 8;
    for (int i = 0; i < N_HOLD; i++) begin
      a = rand_ram_addr();
      write_txn(a, {$urandom, $urandom}, '1);
      mark_written(a);
      read_txn(pick_written());
    end
  endtask

  task automatic run_mixed_traffic();
    addr_t a;
    data_t d;
    test_name = "mixed_traffic";
    hold_max  = 2;
    for (int i = 0; i < N_MIX; i++) begin
      d = {$urandom, $urandom};
      case ($urandom_range(4, 0))
        0, 1: read_txn(pick_written());
        2: begin
          a = rand_ram_addr();
          write_txn(a, d, '1);
          mark_written(a);
        end
        3: write_txn(pick_written(), d, strb_t'($urandom_range(254, 1)));
        default: begin
          if ($urandom_range(1, 0) == 1) begin
            write_txn(SERIAL_ADDR, d, '1);
          end else begin
            read_txn(alias_addr(pick_written()));
          end
        end
      endcase
    end
  endtask

  // response checker samples away from the driving edge
  always @(negedge clk) begin
    if (arst_n_i) begin
      if (rvalid_o && bvalid_o) begin
        report_error("read and write responses valid in the same cycle");
      end
      if (r_hold) begin
        if (!rvalid_o) begin
          report_error("rvalid_o dropped while rready_i was low");
        end else begin
          check_data({test_name, " rdata hold"}, r_hold_data, rdata_o);
          check_resp({test_name, " rresp hold"}, r_hold_resp, rresp_o);
        end
      end
      if (b_hold) begin
        if (!bvalid_o) begin
          report_error("bvalid_o dropped while bready_i was low");
        end else begin
          check_resp({test_name, " bresp hold"}, b_hold_resp, bresp_o);
        end
      end
      if (rvalid_o && rready_i) begin
        if (rd_data_q.size() == 0) begin
          report_error("read response arrived with none outstanding");
        end else begin
          check_data({test_name, " rdata"}, rd_data_q.pop_front(), rdata_o);
          check_resp({test_name, " rresp"}, rd_resp_q.pop_front(), rresp_o);
        end
      end
      if (bvalid_o && bready_i) begin
        if (b_resp_q.size() == 0) begin
          report_error("write response arrived with none outstanding");
        end else begin
          check_resp({test_name, " bresp"}, b_resp_q.pop_front(), bresp_o);
        end
      end
      if (tx_valid_o) begin
        if (tx_q.size() == 0) begin
          report_error("serial strobe with no serial write pending");
        end else begin
          check_byte({test_name, " tx_byte"}, tx_q.pop_front(), tx_byte_o);
        end
      end
      r_hold      = rvalid_o && !rready_i;
      r_hold_data = rdata_o;
      r_hold_resp = rresp_o;
      b_hold      = bvalid_o && !bready_i;
      b_hold_resp = bresp_o;
    end
  end

  initial begin
    int unsigned cycles;
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        report_error("timeout, transactions did not finish in time");
      end
    end
  end

  initial begin
    void'($urandom(32'h6edb7ceb));
    arst_n_i  = 1'b0;
    araddr_i  = '0;
    arvalid_i = 1'b0;
    rready_i  = 1'b0;
    awaddr_i  = '0;
    awvalid_i = 1'b0;
    wdata_i   = '0;
    wstrb_i   = '0;
    wvalid_i  = 1'b0;
    bready_i  = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n_i <= 1'b1;
    repeat (2) @(posedge clk);
    run_full_words();
    run_partial_strobes();
    run_serial_writes();
    run_error_range();
    run_backpressure();
    run_mixed_traffic();
    repeat (4) @(posedge clk);
    if (rd_data_q.size() != 0 || b_resp_q.size() != 0 || tx_q.size() != 0) begin
      report_error("expected responses were never delivered");
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: logic/membus_top.sv
`timescale 1ns/10ps
`default_nettype none

module membus_top import membus_pkg::*; #(
  parameter int unsigned RAM_WORDS   = 256,
  parameter addr_t       SERIAL_ADDR = 32'h1000_03f8,
  parameter bit          STALL_EN    = 1'b1,
  parameter logic [19:0] LFSR_SEED   = 20'd101
) (
  input  wire   clk,
  input  wire   arst_n_i,
  input  addr_t araddr_i,
  input  wire   arvalid_i,
  output logic  arready_o,
  output data_t rdata_o,
  output resp_t rresp_o,
  output logic  rvalid_o,
  input  wire   rready_i,
  input  addr_t awaddr_i,
  input  wire   awvalid_i,
  output logic  awready_o,
  input  data_t wdata_i,
  input  strb_t wstrb_i,
  input  wire   wvalid_i,
  output logic  wready_o,
  output resp_t bresp_o,
  output logic  bvalid_o,
  input  wire   bready_i,
  output byte_t tx_byte_o,
  output logic  tx_valid_o
);

  localparam int unsigned IDX_W = $clog2(RAM_WORDS);

  logic             gate;
  logic             ram_re;
  logic             ram_we;
  logic [IDX_W-1:0] ram_idx;
  data_t            ram_wdata;
  strb_t            ram_strb;
  data_t            ram_rdata;
  logic             ser_we;
  byte_t            ser_byte;

  stall_lfsr #(
    .STALL_EN  (STALL_EN),
    .LFSR_SEED (LFSR_SEED)
  ) stall_lfsr_i (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .gate_o   (gate)
  );

  bus_fsm #(
    .RAM_WORDS   (RAM_WORDS),
    .SERIAL_ADDR (SERIAL_ADDR)
  ) bus_fsm_i (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .gate_i      (gate),
    .araddr_i    (araddr_i),
    .arvalid_i   (arvalid_i),
    .arready_o   (arready_o),
    .rdata_o     (rdata_o),
    .rresp_o     (rresp_o),
    .rvalid_o    (rvalid_o),
    .rready_i    (rready_i),
    .awaddr_i    (awaddr_i),
    .awvalid_i   (awvalid_i),
    .awready_o   (awready_o),
    .wdata_i     (wdata_i),
    .wstrb_i     (wstrb_i),
    .wvalid_i    (wvalid_i),
    .wready_o    (wready_o),
    .bresp_o     (bresp_o),
    .bvalid_o    (bvalid_o),
    .bready_i    (bready_i),
    .ram_re_o    (ram_re),
    .ram_we_o    (ram_we),
    .ram_idx_o   (ram_idx),
    .ram_wdata_o (ram_wdata),
    .ram_strb_o  (ram_strb),
    .ram_rdata_i (ram_rdata),
    .ser_we_o    (ser_we),
    .ser_byte_o  (ser_byte)
  );

  word_ram #(
    .RAM_WORDS (RAM_WORDS)
  ) word_ram_i (
    .clk     (clk),
    .re_i    (ram_re),
    .we_i    (ram_we),
    .idx_i   (ram_idx),
    .wdata_i (ram_wdata),
    .strb_i  (ram_strb),
    .rdata_o (ram_rdata)
  );

  serial_out serial_out_i (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .we_i       (ser_we),
    .byte_i     (ser_byte),
    .tx_byte_o  (tx_byte_o),
    .tx_valid_o (tx_valid_o)
  );

endmodule

`default_nettype wire

// File: logic/serial_out.sv
`timescale 1ns/10ps
`default_nettype none

module serial_out import membus_pkg::*; (
  input  wire   clk,
  input  wire   arst_n_i,
  input  wire   we_i,
  input  byte_t byte_i,
  output byte_t tx_byte_o,
  output logic  tx_valid_o
);

  // one strobe per accepted write
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tx_valid_o <= 1'b0;
    end else begin
      tx_valid_o <= we_i;
    end
  end

  // last character stays on the port
  always_ff @(posedge clk) begin
    if (we_i) begin
      tx_byte_o <= byte_i;
    end
  end

endmodule

`default_nettype wire

// File: logic/word_ram.sv
`timescale 1ns/10ps
`default_nettype none

module word_ram import membus_pkg::*; #(
  parameter int unsigned  RAM_WORDS = 256,
  localparam int unsigned IDX_W     = $clog2(RAM_WORDS)
) (
  input  wire             clk,
  input  wire             re_i,
  input  wire             we_i,
  input  wire [IDX_W-1:0] idx_i,
  input  data_t           wdata_i,
  input  strb_t           strb_i,
  output data_t           rdata_o
);

  data_t mem_q [RAM_WORDS];

  // byte lane writes
  always_ff @(posedge clk) begin
    if (we_i) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (strb_i[b]) begin
          mem_q[idx_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // read port, output holds until the next read
  always_ff @(posedge clk) begin
    if (re_i) begin
      rdata_o <= mem_q[idx_i];
    end
  end

  // single port, the controller must never ask for both
  a_rw_excl: assert property (@(posedge clk) !(re_i && we_i));

endmodule

`default_nettype wire

// File: bus_fsm/bus_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module bus_fsm import membus_pkg::*; #(
  parameter int unsigned  RAM_WORDS   = 256,
  parameter addr_t        SERIAL_ADDR = 32'h1000_03f8,
  localparam int unsigned IDX_W       = $clog2(RAM_WORDS)
) (
  input  wire              clk,
  input  wire              arst_n_i,
  input  wire              gate_i,
  // read address / read data
  input  addr_t            araddr_i,
  input  wire              arvalid_i,
  output logic             arready_o,
  output data_t            rdata_o,
  output resp_t            rresp_o,
  output logic             rvalid_o,
  input  wire              rready_i,
  // write address / write data / write response
  input  addr_t            awaddr_i,
  input  wire              awvalid_i,
  output logic             awready_o,
  input  data_t            wdata_i,
  input  strb_t            wstrb_i,
  input  wire              wvalid_i,
  output logic             wready_o,
  output resp_t            bresp_o,
  output logic             bvalid_o,
  input  wire              bready_i,
  // ram and serial port side
  output logic             ram_re_o,
  output logic             ram_we_o,
  output logic [IDX_W-1:0] ram_idx_o,
  output data_t            ram_wdata_o,
  output strb_t            ram_strb_o,
  input  data_t            ram_rdata_i,
  output logic             ser_we_o,
  output byte_t            ser_byte_o
);

  typedef enum logic [2:0] {IDLE, RACCESS, RRESP, WDATA, BRESP} bus_state_e;

  // first byte address past the ram
  localparam addr_t RAM_LIMIT = addr_t'(RAM_WORDS * 8);

  bus_state_e state_q;
  bus_state_e state_d;
  addr_t      awaddr_q;
  data_t      rdata_q;
  logic       rd_ok_q;
  logic       rd_hit;
  logic       wr_ram;
  logic       wr_ser;

  // serial address never counts as a ram read
  assign rd_hit = (araddr_i < RAM_LIMIT) && (araddr_i != SERIAL_ADDR);
  assign wr_ser = (awaddr_q == SERIAL_ADDR);
  assign wr_ram = (awaddr_q < RAM_LIMIT) && !wr_ser;

  always_comb begin
    state_d   = state_q;
    arready_o = 1'b0;
    awready_o = 1'b0;
    wready_o  = 1'b0;
    case (state_q)
      IDLE: begin
        // reads win over writes
        if (gate_i && arvalid_i) begin
          arready_o = 1'b1;
          state_d   = RACCESS;
        end else if (gate_i && awvalid_i) begin
          awready_o = 1'b1;
          state_d   = WDATA;
        end
      end
      RACCESS: begin
        state_d = RRESP;
      end
      RRESP: begin
        if (rready_i) begin
          state_d = IDLE;
        end
      end
      WDATA: begin
        if (gate_i && wvalid_i) begin
          wready_o = 1'b1;
          state_d  = BRESP;
        end
      end
      BRESP: begin
        if (bready_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (arready_o) begin
      rd_ok_q <= rd_hit;
    end
    if (awready_o) begin
      awaddr_q <= awaddr_i;
    end
    // ram output is valid in RACCESS
    if (state_q == RACCESS) begin
      rdata_q <= rd_ok_q ? ram_rdata_i : '0;
    end
  end

  assign ram_re_o    = arready_o && rd_hit;
  assign ram_we_o    = wready_o && wr_ram;
  assign ser_we_o    = wready_o && wr_ser;
  assign ram_idx_o   = (state_q == IDLE) ? araddr_i[IDX_W+2:3] : awaddr_q[IDX_W+2:3];
  assign ram_wdata_o = wdata_i;
  assign ram_strb_o  = wstrb_i;
  assign ser_byte_o  = wdata_i[7:0];

  assign rvalid_o = (state_q == RRESP);
  assign rdata_o  = rdata_q;
  assign rresp_o  = rd_ok_q ? RESP_OKAY : RESP_SLVERR;
  assign bvalid_o = (state_q == BRESP);
  assign bresp_o  = (wr_ram || wr_ser) ? RESP_OKAY : RESP_SLVERR;

  a_r_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rresp_o));

  a_b_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
    bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o));

endmodule

`default_nettype wire

// File: logic/stall_lfsr.sv
`timescale 1ns/10ps
`default_nettype none

module stall_lfsr #(
  parameter bit          STALL_EN  = 1'b1,
  parameter logic [19:0] LFSR_SEED = 20'd101
) (
  input  wire  clk,
  input  wire  arst_n_i,
  output logic gate_o
);

  logic [19:0] lfsr_q;

  // fibonacci step, taps on the top two bits
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lfsr_q <= LFSR_SEED;
    end else begin
      lfsr_q <= {lfsr_q[18:0], lfsr_q[19] ^ lfsr_q[18]};
    end
  end

  // gate open when high
  always_comb begin
    if (STALL_EN) begin
      gate_o = lfsr_q[19];
    end else begin
      gate_o = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: common/membus_pkg.sv
`default_nettype none

package membus_pkg;

  // bus geometry
  parameter int unsigned ADDR_W = 32;
  parameter int unsigned DATA_W = 64;
  parameter int unsigned STRB_W = DATA_W / 8;

  // byte address as seen on ar/aw channels
  typedef logic [ADDR_W-1:0] addr_t;

  // one bus word
  typedef logic [DATA_W-1:0] data_t;

  // one enable bit per byte lane
  typedef logic [STRB_W-1:0] strb_t;

  // serial port character
  typedef logic [7:0] byte_t;

  typedef logic [1:0] resp_t;

  // response codes, AXI encoding
  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_SLVERR = 2'd2;

endpackage

`default_nettype wire
